/* filelist.f */
verilog/csr_pkg.sv
verilog/csr_regfile.sv
verilog/csr_readback.sv
verilog/csr_top.sv
verif/csr_checker.sv
verif/tb_csr_top.sv

/* verif/csr_checker.sv */
// Shadow register model, reference read function and output comparisons
`timescale 1ns/10ps
`default_nettype none

module csr_checker #(
    parameter logic [3:0] INTERFACE_TYPE = 4'd2,
    parameter logic [7:0] FPGA_FAMILY    = 8'h14
) (
    input  wire logic               clk,
    input  wire logic               rst_n,

    // Host side of the DUT
    input  wire csr_pkg::csr_addr_t addr_i,
    input  wire logic               wr_en_i,
    input  wire csr_pkg::csr_data_t wr_data_i,
    input  wire csr_pkg::csr_data_t rd_data_i,

    // DUT register outputs
    input  wire logic               init_rst_i,
    input  wire logic               mwr_start_i,
    input  wire csr_pkg::csr_data_t mwr_addr_i,
    input  wire logic               mwr_addr_wr_i,
    input  wire csr_pkg::csr_data_t mwr_count_i,
    input  wire csr_pkg::csr_data_t dac_data_i,
    input  wire csr_pkg::csr_data_t config_reg_1_i,
    input  wire csr_pkg::csr_data_t config_reg_2_i,

    output int                      checks_o,
    output int                      errors_o
);

    import csr_pkg::*;

    // Expected DUT state after the most recent edge
    logic      sh_init_rst;
    logic      sh_mwr_start;
    logic      sh_addr_wr;
    csr_data_t sh_mwr_addr;
    csr_data_t sh_count;
    csr_data_t sh_dac;
    csr_data_t sh_cfg1;
    csr_data_t sh_cfg2;
    csr_data_t exp_rd;      // Read word due on the next edge
    logic      armed = 1'b0;

    // ------------------------------------------------------------
    // Reference read word
    // ------------------------------------------------------------
    function automatic csr_data_t expected_read(input csr_addr_t addr);
        csr_data_t word;
        word = 32'h0;   // Write-only and unmapped words
        case (int'(addr))
            0: begin
                word[31:24] = FPGA_FAMILY;
                word[19:16] = INTERFACE_TYPE;
                word[15:8]  = 8'h16;        // Design version
                word[0]     = sh_init_rst;
            end
            3: word = sh_dac;
            4: word = {13'h0000, sh_cfg1[31:13]};  // Upper field right-justified
            5: word = sh_cfg2;
            6: word = sh_count;
            7: word = {19'h00000, sh_cfg1[12:0]};
            default: word = 32'h0;
        endcase
        return word;
    endfunction

    // Shadow update for one observed host cycle
    task automatic apply_write(input logic wr, input csr_addr_t addr, input csr_data_t data);
        sh_addr_wr = wr && (addr == 7'd2);
        if (wr) begin
            case (int'(addr))
                0: sh_init_rst = data[0];
                1: sh_mwr_start = data[0];
                2: sh_mwr_addr = data;
                3: sh_dac = data;
                4: sh_cfg1[31:13] = data[18:0];
                5: sh_cfg2 = data;
                6: sh_count = data;
                7: sh_cfg1[12:0] = data[12:0];
                default: ;  // No register behind it
            endcase
        end
    endtask

    task automatic compare_word(input string name, input csr_data_t expected,
                                input csr_data_t actual);
        checks_o = checks_o + 1;
        if (actual !== expected) begin
            errors_o = errors_o + 1;
            $display("MISMATCH %s expected 0x%08h actual 0x%08h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    // ------------------------------------------------------------
    // Per-edge comparison
    // ------------------------------------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            sh_init_rst  = 1'b0;
            sh_mwr_start = 1'b0;
            sh_addr_wr   = 1'b0;
            sh_mwr_addr  = 32'h0;
            sh_count     = MWR_COUNT_RESET;
            sh_dac       = DAC_RESET;
            sh_cfg1      = CONFIG1_RESET;
            sh_cfg2      = CONFIG2_RESET;
            exp_rd       = 32'h0;
            checks_o     = 0;
            errors_o     = 0;
            armed        = 1'b1;
        end else if (armed) begin
            // Outputs here reflect the previous edge
            compare_word("rd_data_o", exp_rd, rd_data_i);
            compare_word("init_rst_o", {31'h0, sh_init_rst}, {31'h0, init_rst_i});
            compare_word("mwr_start_o", {31'h0, sh_mwr_start}, {31'h0, mwr_start_i});
            compare_word("mwr_addr_wr_o", {31'h0, sh_addr_wr}, {31'h0, mwr_addr_wr_i});
            compare_word("mwr_addr_o", sh_mwr_addr, mwr_addr_i);
            compare_word("mwr_count_o", sh_count, mwr_count_i);
            compare_word("dac_data_o", sh_dac, dac_data_i);
            compare_word("config_reg_1_o", sh_cfg1, config_reg_1_i);
            compare_word("config_reg_2_o", sh_cfg2, config_reg_2_i);
            // Read sees the old value, so compute it before the write
            exp_rd = expected_read(addr_i);
            apply_write(wr_en_i, addr_i, wr_data_i);
        end
    end

endmodule

`default_nettype wire

/* verif/tb_csr_top.sv */
// Testbench top with clock, reset, stimulus, watchdog and DUT instance
`timescale 1ns/10ps
`default_nettype none

module tb_csr_top;

    import csr_pkg::*;

    localparam logic [3:0] INTERFACE_TYPE = 4'd2;
    localparam logic [7:0] FPGA_FAMILY    = 8'h14;

    // Stimulus lengths in one-cycle ops
    localparam int RESET_CYCLES = 10;
    localparam int RAND_WRITES  = 40;
    localparam int CFG_ROUNDS   = 12;
    localparam int ISO_WRITES   = 6;
    localparam int BURST_WRITES = 5;
    localparam int START_WRITES = 6;
    localparam int UNMAPPED_OPS = 30;
    localparam int TOTAL_CYCLES = RESET_CYCLES + 8 + 2 * RAND_WRITES + 4 * CFG_ROUNDS
                                + 3 * ISO_WRITES + BURST_WRITES + 1 + 2 * START_WRITES + 2
                                + 2 * UNMAPPED_OPS + 5 * 3;
    localparam int WATCHDOG_NS  = TOTAL_CYCLES * 20 + 2000;

    logic      clk;
    logic      rst_n;
    csr_addr_t addr;
    logic      wr_en;
    csr_data_t wr_data;
    csr_data_t rd_data;
    logic      init_rst;
    logic      mwr_start;
    logic      mwr_addr_wr;
    csr_data_t mwr_addr;
    csr_data_t mwr_count;
    csr_data_t dac_data;
    csr_data_t config_reg_1;
    csr_data_t config_reg_2;

    int        check_count;
    int        error_count;
    int        tests_run;
    int        tests_failed;
    int        errors_before;
    integer    seed;
    csr_addr_t rw_regs [4] = '{7'd0, 7'd3, 7'd5, 7'd6};   // Plain read/write registers

    // ------------------------------------------------------------
    // Clock, DUT and checker
    // ------------------------------------------------------------
    initial clk = 1'b0;
    always #10 clk = ~clk;

    csr_top #(.INTERFACE_TYPE(INTERFACE_TYPE), .FPGA_FAMILY(FPGA_FAMILY)) DUT (
        .clk(clk), .rst_n(rst_n), .addr_i(addr), .wr_en_i(wr_en), .wr_data_i(wr_data),
        .rd_data_o(rd_data), .init_rst_o(init_rst), .mwr_start_o(mwr_start),
        .mwr_addr_o(mwr_addr), .mwr_addr_wr_o(mwr_addr_wr), .mwr_count_o(mwr_count),
        .dac_data_o(dac_data), .config_reg_1_o(config_reg_1), .config_reg_2_o(config_reg_2)
    );

    csr_checker #(.INTERFACE_TYPE(INTERFACE_TYPE), .FPGA_FAMILY(FPGA_FAMILY)) u_checker (
        .clk(clk), .rst_n(rst_n), .addr_i(addr), .wr_en_i(wr_en), .wr_data_i(wr_data),
        .rd_data_i(rd_data), .init_rst_i(init_rst), .mwr_start_i(mwr_start),
        .mwr_addr_i(mwr_addr), .mwr_addr_wr_i(mwr_addr_wr), .mwr_count_i(mwr_count),
        .dac_data_i(dac_data), .config_reg_1_i(config_reg_1), .config_reg_2_i(config_reg_2),
        .checks_o(check_count), .errors_o(error_count)
    );

    // ------------------------------------------------------------
    // Host bus tasks
    // ------------------------------------------------------------
    function automatic csr_data_t random_word();
        return $random(seed);
    endfunction

    function automatic int random_below(input int limit);
        return ($random(seed) & 32'h7fff_ffff) % limit;
    endfunction

    task automatic write_reg(input csr_addr_t a, input csr_data_t d);
        @(posedge clk);
        addr    <= a;
        wr_en   <= 1'b1;
        wr_data <= d;
    endtask

    task automatic read_reg(input csr_addr_t a);
        @(posedge clk);
        addr    <= a;
        wr_en   <= 1'b0;
        wr_data <= 32'h0;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    // Let the last op reach the checker, then score the test
    task automatic end_test(input string name);
        idle_cycle();
        idle_cycle();
        @(negedge clk);
        tests_run = tests_run + 1;
        if (error_count != errors_before) begin
            tests_failed = tests_failed + 1;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     error_count - errors_before);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
        errors_before = error_count;
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin
        rst_n   = 1'b0;
        addr    = '0;
        wr_en   = 1'b0;
        wr_data = '0;
        seed = 51535;
        tests_run = 0;
        tests_failed = 0;
        errors_before = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < 8; i++) read_reg(csr_addr_t'(i));
        end_test("reset values");

        for (int i = 0; i < RAND_WRITES; i++) begin
            csr_addr_t a;
            a = rw_regs[random_below(4)];
            write_reg(a, random_word());
            read_reg(a);
        end
        end_test("random read/write registers");

        for (int i = 0; i < CFG_ROUNDS; i++) begin
            write_reg(7'd4, random_word());
            read_reg(7'd4);
            write_reg(7'd7, random_word());
            read_reg(7'd7);
        end
        end_test("config word 1 fields");

        for (int i = 0; i < ISO_WRITES; i++) begin
            write_reg(7'd2, random_word());
            idle_cycle();
            idle_cycle();
        end
        repeat (BURST_WRITES) write_reg(7'd2, random_word());   // Pulse stays high
        idle_cycle();
        for (int i = 0; i < START_WRITES; i++) begin
            write_reg(7'd1, random_word());
            read_reg(7'd1);
        end
        read_reg(7'd2);
        read_reg(7'd1);
        end_test("write-only start and queue address");

        for (int i = 0; i < UNMAPPED_OPS; i++) begin
            write_reg(csr_addr_t'(8 + random_below(120)), random_word());
            read_reg(csr_addr_t'(8 + random_below(120)));
        end
        end_test("unmapped addresses");

        $display("summary: %0d tests run, %0d failed, %0d checks, %0d mismatches",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0 && tests_failed == 0 && check_count > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog sized from the stimulus length
    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: simulation hung, watchdog expired at %0t", $time);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/csr_pkg.sv */
// Shared CSR types, register index enum, version and reset constants
`default_nettype none

package csr_pkg;

    // ------------------------------------------------------------
    // Register port types
    // ------------------------------------------------------------
    typedef logic [6:0]  csr_addr_t;    // Word address, 128 slots
    typedef logic [31:0] csr_data_t;    // Register and bus data

    // Register index, one entry per mapped word
    typedef enum logic [6:0] {
        CSR_ID_RESET   = 7'd0,  // ID word, initiator reset in bit 0
        CSR_MWR_START  = 7'd1,  // Memory write start, write only
        CSR_QUEUE_ADDR = 7'd2,  // Write queue address, write only
        CSR_DAC        = 7'd3,  // DAC setting
        CSR_CONFIG1_HI = 7'd4,  // Upper field of config word 1
        CSR_CONFIG2    = 7'd5,  // Config word 2
        CSR_MWR_COUNT  = 7'd6,  // Write packet count
        CSR_FRAME_LEN  = 7'd7   // Lower field of config word 1
    } csr_reg_e;

    // ------------------------------------------------------------
    // Config word 1 split
    // ------------------------------------------------------------
    // Frame length sits in the low bits, the rest of the word above it.
    // The two widths add up to the full data width.
    localparam int CFG1_LO_WIDTH = 13;
    localparam int CFG1_HI_WIDTH = 19;

    // ------------------------------------------------------------
    // Identification
    // ------------------------------------------------------------
    localparam logic [7:0] VERSION_NUMBER = 8'h16;

    // ------------------------------------------------------------
    // Reset values
    // ------------------------------------------------------------
    // DAC channels start at mid scale
    localparam csr_data_t DAC_RESET = 32'h8080_8080;

    // Frame length all ones, bit 16 set in the upper field
    localparam csr_data_t CONFIG1_RESET = 32'h0001_1FFF;

    localparam csr_data_t CONFIG2_RESET = 32'h0002_0000;

    // Default buffer of 32768 packets
    localparam csr_data_t MWR_COUNT_RESET = 32'd32768;

endpackage

`default_nettype wire

/* verilog/csr_readback.sv */
// CSR read data selection with the identification word
`timescale 1ns/10ps
`default_nettype none

module csr_readback #(
    parameter logic [3:0] INTERFACE_TYPE = 4'd2,
    parameter logic [7:0] FPGA_FAMILY    = 8'h14
) (
    input  wire logic               clk,
    input  wire logic               rst_n,

    input  wire csr_pkg::csr_addr_t addr_i,

    // Current register values
    input  wire logic               init_rst_i,
    input  wire csr_pkg::csr_data_t dac_data_i,
    input  wire csr_pkg::csr_data_t mwr_count_i,
    input  wire csr_pkg::csr_data_t config_reg_1_i,
    input  wire csr_pkg::csr_data_t config_reg_2_i,

    output csr_pkg::csr_data_t      rd_data_o
);

    import csr_pkg::*;

    csr_data_t rd_next;
    csr_data_t id_word;

    // Family, bus type, version and the reset bit in one word
    assign id_word = {FPGA_FAMILY, 4'b0000, INTERFACE_TYPE,
                      VERSION_NUMBER, 7'b0000000, init_rst_i};

    // ------------------------------------------------------------
    // Read word select
    // ------------------------------------------------------------
    always_comb begin
        rd_next = '0;   // Write-only and unmapped words read zero
        case (csr_reg_e'(addr_i))
            CSR_ID_RESET:   rd_next = id_word;
            CSR_DAC:        rd_next = dac_data_i;
            CSR_CONFIG1_HI: begin
                // Upper field comes back right-justified
                rd_next[CFG1_HI_WIDTH-1:0] =
                    config_reg_1_i[CFG1_LO_WIDTH +: CFG1_HI_WIDTH];
            end
            CSR_CONFIG2:    rd_next = config_reg_2_i;
            CSR_MWR_COUNT:  rd_next = mwr_count_i;
            CSR_FRAME_LEN: begin
                rd_next[CFG1_LO_WIDTH-1:0] = config_reg_1_i[CFG1_LO_WIDTH-1:0];
            end
            default: begin
                rd_next = '0;
            end
        endcase
    end

    // One cycle read latency, values sampled before any same-edge write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_data_o <= '0;
        end else begin
            rd_data_o <= rd_next;
        end
    end

    // ------------------------------------------------------------
    // Assertions
    // ------------------------------------------------------------
    a_rd_data_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(rd_data_o)
    ) else $error("rd_data_o unknown after reset");

endmodule

`default_nettype wire

/* verilog/csr_regfile.sv */
// CSR register storage, write decode and queue address written pulse
`timescale 1ns/10ps
`default_nettype none

module csr_regfile (
    input  wire logic              clk,
    input  wire logic              rst_n,

    // Host register port
    input  wire csr_pkg::csr_addr_t addr_i,
    input  wire logic              wr_en_i,
    input  wire csr_pkg::csr_data_t wr_data_i,

    // Register contents
    output logic                   init_rst_o,
    output logic                   mwr_start_o,
    output logic                   mwr_addr_wr_o,  // One cycle per queue write
    output csr_pkg::csr_data_t     mwr_addr_o,
    output csr_pkg::csr_data_t     mwr_count_o,
    output csr_pkg::csr_data_t     dac_data_o,
    output csr_pkg::csr_data_t     config_reg_1_o,
    output csr_pkg::csr_data_t     config_reg_2_o
);

    import csr_pkg::*;

    csr_reg_e                 reg_sel;
    logic                     queue_wr;
    logic [CFG1_HI_WIDTH-1:0] cfg1_hi_q;   // Upper field of config word 1
    logic [CFG1_LO_WIDTH-1:0] cfg1_lo_q;   // Frame length

    // ------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------
    assign reg_sel  = csr_reg_e'(addr_i);
    assign queue_wr = wr_en_i && (reg_sel == CSR_QUEUE_ADDR);

    // Config word 1 is kept as two fields written from separate addresses
    assign config_reg_1_o = {cfg1_hi_q, cfg1_lo_q};

    // ------------------------------------------------------------
    // Register writes
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init_rst_o     <= 1'b0;
            mwr_start_o    <= 1'b0;
            mwr_addr_o     <= '0;
            dac_data_o     <= DAC_RESET;
            cfg1_hi_q      <= CONFIG1_RESET[CFG1_LO_WIDTH +: CFG1_HI_WIDTH];
            cfg1_lo_q      <= CONFIG1_RESET[CFG1_LO_WIDTH-1:0];
            config_reg_2_o <= CONFIG2_RESET;
            mwr_count_o    <= MWR_COUNT_RESET;
        end else if (wr_en_i) begin
            case (reg_sel)
                CSR_ID_RESET: begin
                    init_rst_o <= wr_data_i[0];
                end
                CSR_MWR_START: begin
                    mwr_start_o <= wr_data_i[0];   // Only bit 0 stored
                end
                CSR_QUEUE_ADDR: begin
                    mwr_addr_o <= wr_data_i;
                end
                CSR_DAC: begin
                    dac_data_o <= wr_data_i;
                end
                CSR_CONFIG1_HI: begin
                    // Field arrives right-justified on the bus
                    cfg1_hi_q <= wr_data_i[CFG1_HI_WIDTH-1:0];
                end
                CSR_CONFIG2: begin
                    config_reg_2_o <= wr_data_i;
                end
                CSR_MWR_COUNT: begin
                    mwr_count_o <= wr_data_i;
                end
                CSR_FRAME_LEN: begin
                    cfg1_lo_q <= wr_data_i[CFG1_LO_WIDTH-1:0];
                end
                default: begin
                    // Unmapped address drops the write
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    // Queue address written pulse
    // ------------------------------------------------------------
    // Follows each queue write by one cycle; back-to-back writes hold it high
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mwr_addr_wr_o <= 1'b0;
        end else begin
            mwr_addr_wr_o <= queue_wr;
        end
    end

    // ------------------------------------------------------------
    // Assertions
    // ------------------------------------------------------------
    // Pulse only ever follows a queue address write on the host port
    a_addr_wr_source: assert property (
        @(posedge clk) disable iff (!rst_n)
        mwr_addr_wr_o |-> ($past(wr_en_i) && ($past(addr_i) == CSR_QUEUE_ADDR))
    ) else $error("mwr_addr_wr_o high without a preceding queue write");

    // Outputs settle to known values out of reset
    a_outputs_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown({init_rst_o, mwr_start_o, mwr_addr_wr_o, mwr_addr_o,
                     mwr_count_o, dac_data_o, config_reg_1_o, config_reg_2_o})
    ) else $error("register output unknown after reset");

endmodule

`default_nettype wire

/* verilog/csr_top.sv */
// CSR block top level joining register file and readback
`timescale 1ns/10ps
`default_nettype none

module csr_top #(
    parameter logic [3:0] INTERFACE_TYPE = 4'd2,    // Data path width code
    parameter logic [7:0] FPGA_FAMILY    = 8'h14    // Device family code
) (
    input  wire logic               clk,
    input  wire logic               rst_n,

    // ------------------------------------------------------------
    // Host register port
    // ------------------------------------------------------------
    input  wire csr_pkg::csr_addr_t addr_i,
    input  wire logic               wr_en_i,
    input  wire csr_pkg::csr_data_t wr_data_i,
    output wire csr_pkg::csr_data_t rd_data_o,

    // ------------------------------------------------------------
    // Register contents to the DMA engine
    // ------------------------------------------------------------
    output wire logic               init_rst_o,      // Initiator reset
    output wire logic               mwr_start_o,     // Memory write start
    output wire csr_pkg::csr_data_t mwr_addr_o,      // Write queue address
    output wire logic               mwr_addr_wr_o,   // Queue address written
    output wire csr_pkg::csr_data_t mwr_count_o,     // Write packet count
    output wire csr_pkg::csr_data_t dac_data_o,
    output wire csr_pkg::csr_data_t config_reg_1_o,
    output wire csr_pkg::csr_data_t config_reg_2_o
);

    // ------------------------------------------------------------
    // Register storage and write decode
    // ------------------------------------------------------------
    csr_regfile u_regfile (
        .clk            (clk),
        .rst_n          (rst_n),
        .addr_i         (addr_i),
        .wr_en_i        (wr_en_i),
        .wr_data_i      (wr_data_i),
        .init_rst_o     (init_rst_o),
        .mwr_start_o    (mwr_start_o),
        .mwr_addr_wr_o  (mwr_addr_wr_o),
        .mwr_addr_o     (mwr_addr_o),
        .mwr_count_o    (mwr_count_o),
        .dac_data_o     (dac_data_o),
        .config_reg_1_o (config_reg_1_o),
        .config_reg_2_o (config_reg_2_o)
    );

    // ------------------------------------------------------------
    // Read data path
    // ------------------------------------------------------------
    // Start and queue address are write only, so not routed here
    csr_readback #(
        .INTERFACE_TYPE (INTERFACE_TYPE),
        .FPGA_FAMILY    (FPGA_FAMILY)
    ) u_readback (
        .clk            (clk),
        .rst_n          (rst_n),
        .addr_i         (addr_i),
        .init_rst_i     (init_rst_o),
        .dac_data_i     (dac_data_o),
        .mwr_count_i    (mwr_count_o),
        .config_reg_1_i (config_reg_1_o),
        .config_reg_2_i (config_reg_2_o),
        .rd_data_o      (rd_data_o)
    );

endmodule

`default_nettype wire
